/* Makefile */
SIM := obj_dir/Vcsr_unit_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): files.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module csr_unit_tb -f files.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* files.f */
rtl/csr_addr_pkg.sv
rtl/csr_trap_pkg.sv
rtl/csr_bus_if.sv
rtl/csr_field_reg.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_unit.sv
sim/csr_unit_tb.sv

/* rtl/csr_addr_pkg.sv */
package csr_addr_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // machine mode csr addresses
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam logic [11:0] CSR_MSTATUS   = 12'h300;
   localparam logic [11:0] CSR_MISA      = 12'h301;
   localparam logic [11:0] CSR_MTVEC     = 12'h305;
   localparam logic [11:0] CSR_MSTATUSH  = 12'h310;
   localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
   localparam logic [11:0] CSR_MEPC      = 12'h341;
   localparam logic [11:0] CSR_MCAUSE    = 12'h342;
   localparam logic [11:0] CSR_MTVAL     = 12'h343;

   // counters
   localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
   localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
   localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
   localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operations and payloads
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // 2'b00 is not a csr op, the decoder turns it into a no-op
   typedef enum logic [1:0] {
      OP_RW = 2'b01,
      OP_RS = 2'b10,
      OP_RC = 2'b11
   } csr_op_t;

   typedef logic [31:0] csr_word_t;

   // mode 0 direct, 1 vectored
   typedef struct packed {
      logic [29:0] base;
      logic [1:0]  mode;
   } mtvec_t;

   typedef struct packed {
      logic [1:0]  mxl;
      logic [3:0]  zero;
      logic [25:0] ext;
   } misa_t;

endpackage

/* rtl/csr_bus_if.sv */
`timescale 1ns/1ps

// decoded write bus, shared by all csr register modules
interface csr_bus_if;

   logic                    en;
   logic [11:0]             addr;
   csr_addr_pkg::csr_word_t set;
   csr_addr_pkg::csr_word_t clear;

   modport dec (
      output en,
      output addr,
      output set,
      output clear
   );

   modport regs (
      input en,
      input addr,
      input set,
      input clear
   );

endinterface

/* rtl/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters (
   input  logic        clk_i,
   input  logic        rst_i,

   csr_bus_if.regs     bus,

   input  logic        instr_retired_i,

   output logic        ack_o,
   output logic [31:0] value_o
);

   logic [63:0] mcycle_q;
   logic [63:0] minstret_q;

   logic        sel_cycle_lo;
   logic        sel_cycle_hi;
   logic        sel_instret_lo;
   logic        sel_instret_hi;
   logic        has_write;

   // replaces one 32-bit half of a counter with its set/clear result
   function automatic logic [63:0] write_half(
      input logic [63:0]             count,
      input logic                    upper,
      input csr_addr_pkg::csr_word_t set_bits,
      input csr_addr_pkg::csr_word_t clear_bits
   );
      logic [31:0] half;
      half = upper ? count[63:32] : count[31:0];
      half = (half | set_bits) & ~clear_bits;
      return upper ? {half, count[31:0]} : {count[63:32], half};
   endfunction

   assign sel_cycle_lo   = bus.en && (bus.addr == csr_addr_pkg::CSR_MCYCLE);
   assign sel_cycle_hi   = bus.en && (bus.addr == csr_addr_pkg::CSR_MCYCLEH);
   assign sel_instret_lo = bus.en && (bus.addr == csr_addr_pkg::CSR_MINSTRET);
   assign sel_instret_hi = bus.en && (bus.addr == csr_addr_pkg::CSR_MINSTRETH);
   assign ack_o = sel_cycle_lo | sel_cycle_hi | sel_instret_lo | sel_instret_hi;

   // set and clear both zero is a pure read, the counter keeps running
   assign has_write = |(bus.set | bus.clear);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mcycle_q <= '0;
      end else if ((sel_cycle_lo || sel_cycle_hi) && has_write) begin
         mcycle_q <= write_half(mcycle_q, sel_cycle_hi, bus.set, bus.clear);
      end else begin
         mcycle_q <= mcycle_q + 64'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         minstret_q <= '0;
      end else if ((sel_instret_lo || sel_instret_hi) && has_write) begin
         minstret_q <= write_half(minstret_q, sel_instret_hi, bus.set, bus.clear);
      end else if (instr_retired_i) begin
         minstret_q <= minstret_q + 64'd1;
      end
   end

   always_comb begin
      case (bus.addr)
         csr_addr_pkg::CSR_MCYCLE:    value_o = mcycle_q[31:0];
         csr_addr_pkg::CSR_MCYCLEH:   value_o = mcycle_q[63:32];
         csr_addr_pkg::CSR_MINSTRET:  value_o = minstret_q[31:0];
         csr_addr_pkg::CSR_MINSTRETH: value_o = minstret_q[63:32];
         default:                     value_o = '0;
      endcase
   end

endmodule

/* rtl/csr_field_reg.sv */
`timescale 1ns/1ps

module csr_field_reg #(
   parameter type         T           = csr_addr_pkg::csr_word_t,
   parameter logic [11:0] ADDRESS     = 12'h000,
   parameter logic [31:0] RESET_VALUE = 32'h0000_0000,
   parameter logic [31:0] WRITE_MASK  = 32'hFFFF_FFFF
) (
   input  logic    clk_i,
   input  logic    rst_i,

   csr_bus_if.regs bus,

   output logic    ack_o,
   output T        value_o
);

   logic [31:0] value_q;
   logic [31:0] masked_next;

   assign ack_o = bus.en && (bus.addr == ADDRESS);

   // read-set-clear on writable bits, the rest keep their reset value
   assign masked_next = (value_q & ~WRITE_MASK)
                      | (((value_q | bus.set) & ~bus.clear) & WRITE_MASK);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         value_q <= RESET_VALUE;
      end else if (ack_o) begin
         value_q <= masked_next;
      end
   end

   assign value_o = T'(value_q);

   // read-only fields hold their reset value for the whole run
   a_fixed_bits : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (value_q & ~WRITE_MASK) == (RESET_VALUE & ~WRITE_MASK)
   ) else $error("csr %h: read-only bits changed, value %h", ADDRESS, value_q);

endmodule

/* rtl/csr_trap_pkg.sv */
package csr_trap_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // synchronous exception causes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [3:0] {
      EXC_INSTR_MISALIGNED = 4'd0,
      EXC_INSTR_FAULT      = 4'd1,
      EXC_ILLEGAL_INSTR    = 4'd2,
      EXC_BREAKPOINT       = 4'd3,
      EXC_LOAD_MISALIGNED  = 4'd4,
      EXC_LOAD_FAULT       = 4'd5,
      EXC_STORE_MISALIGNED = 4'd6,
      EXC_STORE_FAULT      = 4'd7,
      EXC_ECALL_U          = 4'd8,
      EXC_ECALL_S          = 4'd9,
      EXC_ECALL_M          = 4'd11
   } exc_code_t;

   // mstatus fields, mpp is two bits wide
   localparam int MSTATUS_MIE_BIT  = 3;
   localparam int MSTATUS_MPIE_BIT = 7;
   localparam int MSTATUS_MPP_LSB  = 11;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // misa extension letters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int MISA_A_BIT = 0;
   localparam int MISA_B_BIT = 1;
   localparam int MISA_F_BIT = 5;
   localparam int MISA_I_BIT = 8;
   localparam int MISA_M_BIT = 12;

   // only these extensions can be switched by software
   localparam logic [31:0] MISA_WRITABLE = (32'd1 << MISA_A_BIT)
                                         | (32'd1 << MISA_B_BIT)
                                         | (32'd1 << MISA_F_BIT)
                                         | (32'd1 << MISA_M_BIT);

endpackage

/* rtl/csr_trap_regs.sv */
`timescale 1ns/1ps

module csr_trap_regs (
   input  logic                     clk_i,
   input  logic                     rst_i,

   csr_bus_if.regs                  bus,

   input  logic                     exception_detected_i,
   input  logic                     mret_i,
   input  csr_trap_pkg::exc_code_t  exception_i,
   input  logic [31:2]              pc_last_i,

   output logic                     ack_o,
   output logic [31:0]              value_o,
   output logic [31:0]              mepc_o
);

   logic        mie_q;
   logic        mpie_q;
   logic [31:2] mepc_q;
   logic [31:0] mcause_q;

   logic        sel_mstatus;
   logic        sel_mepc;
   logic        sel_mcause;

   logic [31:0] mstatus_value;
   logic [31:0] mstatus_next;
   logic [31:0] mepc_next;
   logic [31:0] mcause_next;

   assign sel_mstatus = bus.en && (bus.addr == csr_addr_pkg::CSR_MSTATUS);
   assign sel_mepc    = bus.en && (bus.addr == csr_addr_pkg::CSR_MEPC);
   assign sel_mcause  = bus.en && (bus.addr == csr_addr_pkg::CSR_MCAUSE);
   assign ack_o       = sel_mstatus | sel_mepc | sel_mcause;

   // machine mode only, so mpp always reads 3
   always_comb begin
      mstatus_value = '0;
      mstatus_value[csr_trap_pkg::MSTATUS_MIE_BIT]       = mie_q;
      mstatus_value[csr_trap_pkg::MSTATUS_MPIE_BIT]      = mpie_q;
      mstatus_value[csr_trap_pkg::MSTATUS_MPP_LSB +: 2]  = 2'b11;
   end

   assign mstatus_next = (mstatus_value | bus.set) & ~bus.clear;
   assign mepc_next    = ({mepc_q, 2'b00} | bus.set) & ~bus.clear;
   assign mcause_next  = (mcause_q | bus.set) & ~bus.clear;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // mstatus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mie_q  <= 1'b0;
         mpie_q <= 1'b0;
      end else if (exception_detected_i) begin
         mpie_q <= mie_q;
         mie_q  <= 1'b0;
      end else if (mret_i) begin
         mie_q  <= mpie_q;
         mpie_q <= 1'b1;
      end else if (sel_mstatus) begin
         mie_q  <= mstatus_next[csr_trap_pkg::MSTATUS_MIE_BIT];
         mpie_q <= mstatus_next[csr_trap_pkg::MSTATUS_MPIE_BIT];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // mepc and mcause
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mepc_q   <= '0;
         mcause_q <= '0;
      end else if (exception_detected_i) begin
         // trap entry overrides a software write in the same cycle
         mepc_q   <= pc_last_i;
         mcause_q <= {28'b0, exception_i};
      end else begin
         if (sel_mepc) begin
            mepc_q <= mepc_next[31:2];
         end
         if (sel_mcause) begin
            mcause_q <= mcause_next;
         end
      end
   end

   always_comb begin
      case (bus.addr)
         csr_addr_pkg::CSR_MSTATUS: value_o = mstatus_value;
         csr_addr_pkg::CSR_MEPC:    value_o = {mepc_q, 2'b00};
         csr_addr_pkg::CSR_MCAUSE:  value_o = mcause_q;
         default:                   value_o = '0;
      endcase
   end

   assign mepc_o = {mepc_q, 2'b00};

   // the pipeline retires an mret only when no trap is pending
   a_trap_mret_excl : assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(exception_detected_i && mret_i)
   ) else $error("exception and mret raised in the same cycle");

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit #(
   // mxl = 1 with I, M and A present
   parameter logic [31:0] MISA_RESET  = 32'h4000_0000
                                      | (32'd1 << csr_trap_pkg::MISA_I_BIT)
                                      | (32'd1 << csr_trap_pkg::MISA_M_BIT)
                                      | (32'd1 << csr_trap_pkg::MISA_A_BIT),
   parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
   input  logic        clk_i,
   input  logic        rst_i,

   input  logic        en_i,
   input  logic [1:0]  op_i,
   input  logic        source_sel_i,  // 0 = rs1, 1 = uimm

   input  logic        mret_i,
   input  logic        instr_retired_i,
   input  logic        exception_detected_i,
   input  logic [3:0]  exception_i,
   input  logic [31:2] pc_last_i,

   input  logic [4:0]  rs1_label_i,
   input  logic [31:0] rs1_value_i,

   input  logic [11:0] addr_i,

   output logic [31:0] read_o,
   output logic [31:0] mtvec_o,
   output logic [31:0] mepc_o,
   output logic        illegal_o,

   output logic        is_a_supported_o,
   output logic        is_b_supported_o,
   output logic        is_f_supported_o,
   output logic        is_m_supported_o
);

   csr_addr_pkg::csr_word_t source;
   csr_addr_pkg::csr_word_t mscratch_value;
   csr_addr_pkg::mtvec_t    mtvec_value;
   csr_addr_pkg::misa_t     misa_value;
   logic [31:0]             trap_value;
   logic [31:0]             counter_value;

   logic mscratch_ack;
   logic mtvec_ack;
   logic misa_ack;
   logic trap_ack;
   logic counter_ack;
   logic mstatush_ack;
   logic mtval_ack;
   logic [6:0] acks;

   csr_bus_if bus ();

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // write decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign source = source_sel_i ? {27'b0, rs1_label_i} : rs1_value_i;

   assign bus.en   = en_i;
   assign bus.addr = addr_i;

   always_comb begin
      case (csr_addr_pkg::csr_op_t'(op_i))
         csr_addr_pkg::OP_RW: begin
            bus.set   = source;
            bus.clear = ~source;
         end
         csr_addr_pkg::OP_RS: begin
            bus.set   = source;
            bus.clear = '0;
         end
         csr_addr_pkg::OP_RC: begin
            bus.set   = '0;
            bus.clear = source;
         end
         default: begin
            bus.set   = '0;
            bus.clear = '0;
         end
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   csr_field_reg #(
      .T           (csr_addr_pkg::csr_word_t),
      .ADDRESS     (csr_addr_pkg::CSR_MSCRATCH),
      .RESET_VALUE (32'h0000_0000),
      .WRITE_MASK  (32'hFFFF_FFFF)
   ) u_mscratch (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .bus     (bus),
      .ack_o   (mscratch_ack),
      .value_o (mscratch_value)
   );

   csr_field_reg #(
      .T           (csr_addr_pkg::mtvec_t),
      .ADDRESS     (csr_addr_pkg::CSR_MTVEC),
      .RESET_VALUE (MTVEC_RESET),
      .WRITE_MASK  (32'hFFFF_FFFF)
   ) u_mtvec (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .bus     (bus),
      .ack_o   (mtvec_ack),
      .value_o (mtvec_value)
   );

   csr_field_reg #(
      .T           (csr_addr_pkg::misa_t),
      .ADDRESS     (csr_addr_pkg::CSR_MISA),
      .RESET_VALUE (MISA_RESET),
      .WRITE_MASK  (csr_trap_pkg::MISA_WRITABLE)
   ) u_misa (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .bus     (bus),
      .ack_o   (misa_ack),
      .value_o (misa_value)
   );

   csr_trap_regs u_trap (
      .clk_i                (clk_i),
      .rst_i                (rst_i),
      .bus                  (bus),
      .exception_detected_i (exception_detected_i),
      .mret_i               (mret_i),
      .exception_i          (csr_trap_pkg::exc_code_t'(exception_i)),
      .pc_last_i            (pc_last_i),
      .ack_o                (trap_ack),
      .value_o              (trap_value),
      .mepc_o               (mepc_o)
   );

   csr_counters u_counters (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .bus             (bus),
      .instr_retired_i (instr_retired_i),
      .ack_o           (counter_ack),
      .value_o         (counter_value)
   );

   // mstatush and mtval exist but always read zero
   assign mstatush_ack = en_i && (addr_i == csr_addr_pkg::CSR_MSTATUSH);
   assign mtval_ack    = en_i && (addr_i == csr_addr_pkg::CSR_MTVAL);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read mux
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign acks = {mscratch_ack, mtvec_ack, misa_ack, trap_ack,
                  counter_ack, mstatush_ack, mtval_ack};

   assign read_o = (mscratch_ack ? mscratch_value : 32'h0)
                 | (mtvec_ack    ? mtvec_value    : 32'h0)
                 | (misa_ack     ? misa_value     : 32'h0)
                 | (trap_ack     ? trap_value     : 32'h0)
                 | (counter_ack  ? counter_value  : 32'h0);

   assign illegal_o = en_i && !(|acks);

   assign mtvec_o = mtvec_value;

   assign is_a_supported_o = misa_value.ext[csr_trap_pkg::MISA_A_BIT];
   assign is_b_supported_o = misa_value.ext[csr_trap_pkg::MISA_B_BIT];
   assign is_f_supported_o = misa_value.ext[csr_trap_pkg::MISA_F_BIT];
   assign is_m_supported_o = misa_value.ext[csr_trap_pkg::MISA_M_BIT];

   // address decode across all register modules must not overlap
   a_single_ack : assert property (
      @(posedge clk_i) disable iff (rst_i)
      $onehot0(acks)
   ) else $error("several csr blocks acked address %h, acks %b", addr_i, acks);

endmodule

/* sim/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;

   localparam logic [31:0] MISA_RESET  = 32'h4000_1101;
   localparam logic [31:0] MTVEC_RESET = 32'h8000_0101;

   logic        clk_i, rst_i, en_i, source_sel_i;
   logic        mret_i, instr_retired_i, exception_detected_i;
   logic [1:0]  op_i;
   logic [4:0]  rs1_label_i;
   logic [31:0] rs1_value_i;
   logic [11:0] addr_i;
   logic [3:0]  exception_i;
   logic [31:2] pc_last_i;

   logic [31:0] read_o, mtvec_o, mepc_o;
   logic        illegal_o;
   logic        is_a_supported_o, is_b_supported_o, is_f_supported_o, is_m_supported_o;

   // reference model state
   logic [31:0] m_mscratch, m_mtvec, m_misa, m_mepc, m_mcause;
   logic        m_mie, m_mpie;
   logic [63:0] m_mcycle, m_minstret;

   logic [31:0] src, exp_read, status_next;
   logic        exp_illegal, writes;
   logic [3:0]  flags, exp_flags;
   logic [31:0] seed;
   int          errors;
   int          accesses;

   csr_unit #(
      .MISA_RESET  (MISA_RESET),
      .MTVEC_RESET (MTVEC_RESET)
   ) dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [1:0] pick_op(input logic [31:0] r);
      case (r[1:0])
         2'd1:    return csr_addr_pkg::OP_RS;
         2'd2:    return csr_addr_pkg::OP_RC;
         default: return csr_addr_pkg::OP_RW;
      endcase
   endfunction

   // result of one csr instruction on an old value
   function automatic logic [31:0] apply_op(input logic [31:0] old, input logic [1:0] op,
                                            input logic [31:0] s);
      case (op)
         csr_addr_pkg::OP_RW: return s;
         csr_addr_pkg::OP_RS: return old | s;
         csr_addr_pkg::OP_RC: return old & ~s;
         default:             return old;
      endcase
   endfunction

   function automatic logic [31:0] status_word(input logic mie, input logic mpie);
      logic [31:0] w;
      w = 32'h0;
      w[csr_trap_pkg::MSTATUS_MIE_BIT]      = mie;
      w[csr_trap_pkg::MSTATUS_MPIE_BIT]     = mpie;
      w[csr_trap_pkg::MSTATUS_MPP_LSB +: 2] = 2'b11;
      return w;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      src         = source_sel_i ? {27'b0, rs1_label_i} : rs1_value_i;
      writes      = (op_i == csr_addr_pkg::OP_RW) || (src != 32'h0);
      status_next = apply_op(status_word(m_mie, m_mpie), op_i, src);
      exp_illegal = 1'b0;
      case (addr_i)
         csr_addr_pkg::CSR_MSTATUS:   exp_read = status_word(m_mie, m_mpie);
         csr_addr_pkg::CSR_MISA:      exp_read = m_misa;
         csr_addr_pkg::CSR_MTVEC:     exp_read = m_mtvec;
         csr_addr_pkg::CSR_MSCRATCH:  exp_read = m_mscratch;
         csr_addr_pkg::CSR_MEPC:      exp_read = m_mepc;
         csr_addr_pkg::CSR_MCAUSE:    exp_read = m_mcause;
         csr_addr_pkg::CSR_MTVAL:     exp_read = 32'h0;
         csr_addr_pkg::CSR_MSTATUSH:  exp_read = 32'h0;
         csr_addr_pkg::CSR_MCYCLE:    exp_read = m_mcycle[31:0];
         csr_addr_pkg::CSR_MCYCLEH:   exp_read = m_mcycle[63:32];
         csr_addr_pkg::CSR_MINSTRET:  exp_read = m_minstret[31:0];
         csr_addr_pkg::CSR_MINSTRETH: exp_read = m_minstret[63:32];
         default: begin
            exp_read    = 32'h0;
            exp_illegal = 1'b1;
         end
      endcase
      if (!en_i) begin
         exp_read    = 32'h0;
         exp_illegal = 1'b0;
      end
      exp_flags = {m_misa[csr_trap_pkg::MISA_A_BIT], m_misa[csr_trap_pkg::MISA_B_BIT],
                   m_misa[csr_trap_pkg::MISA_F_BIT], m_misa[csr_trap_pkg::MISA_M_BIT]};
   end

   assign flags = {is_a_supported_o, is_b_supported_o, is_f_supported_o, is_m_supported_o};

   always @(posedge clk_i) begin
      if (rst_i) begin
         m_mscratch <= 32'h0;
         m_mtvec    <= MTVEC_RESET;
         m_misa     <= MISA_RESET;
         m_mepc     <= 32'h0;
         m_mcause   <= 32'h0;
         m_mie      <= 1'b0;
         m_mpie     <= 1'b0;
         m_mcycle   <= 64'h0;
         m_minstret <= 64'h0;
      end else begin
         if (en_i && addr_i == csr_addr_pkg::CSR_MSCRATCH)
            m_mscratch <= apply_op(m_mscratch, op_i, src);
         if (en_i && addr_i == csr_addr_pkg::CSR_MTVEC)
            m_mtvec <= apply_op(m_mtvec, op_i, src);
         if (en_i && addr_i == csr_addr_pkg::CSR_MISA)
            m_misa <= (m_misa & ~csr_trap_pkg::MISA_WRITABLE)
                    | (apply_op(m_misa, op_i, src) & csr_trap_pkg::MISA_WRITABLE);

         // trap entry beats mret and software writes
         if (exception_detected_i) begin
            m_mpie   <= m_mie;
            m_mie    <= 1'b0;
            m_mepc   <= {pc_last_i, 2'b00};
            m_mcause <= {28'h0, exception_i};
         end else begin
            if (mret_i) begin
               m_mie  <= m_mpie;
               m_mpie <= 1'b1;
            end else if (en_i && addr_i == csr_addr_pkg::CSR_MSTATUS) begin
               m_mie  <= status_next[csr_trap_pkg::MSTATUS_MIE_BIT];
               m_mpie <= status_next[csr_trap_pkg::MSTATUS_MPIE_BIT];
            end
            if (en_i && addr_i == csr_addr_pkg::CSR_MEPC)
               m_mepc <= apply_op(m_mepc, op_i, src) & 32'hFFFF_FFFC;
            if (en_i && addr_i == csr_addr_pkg::CSR_MCAUSE)
               m_mcause <= apply_op(m_mcause, op_i, src);
         end

         // a counter write beats the increment
         if (en_i && writes && addr_i == csr_addr_pkg::CSR_MCYCLE)
            m_mcycle[31:0] <= apply_op(m_mcycle[31:0], op_i, src);
         else if (en_i && writes && addr_i == csr_addr_pkg::CSR_MCYCLEH)
            m_mcycle[63:32] <= apply_op(m_mcycle[63:32], op_i, src);
         else
            m_mcycle <= m_mcycle + 64'd1;

         if (en_i && writes && addr_i == csr_addr_pkg::CSR_MINSTRET)
            m_minstret[31:0] <= apply_op(m_minstret[31:0], op_i, src);
         else if (en_i && writes && addr_i == csr_addr_pkg::CSR_MINSTRETH)
            m_minstret[63:32] <= apply_op(m_minstret[63:32], op_i, src);
         else if (instr_retired_i)
            m_minstret <= m_minstret + 64'd1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
   endtask

   a_read : assert property (@(posedge clk_i) disable iff (rst_i) read_o == exp_read)
      else report_mismatch("read_o", $sampled(read_o), $sampled(exp_read));
   a_mtvec : assert property (@(posedge clk_i) disable iff (rst_i) mtvec_o == m_mtvec)
      else report_mismatch("mtvec_o", $sampled(mtvec_o), $sampled(m_mtvec));
   a_mepc : assert property (@(posedge clk_i) disable iff (rst_i) mepc_o == m_mepc)
      else report_mismatch("mepc_o", $sampled(mepc_o), $sampled(m_mepc));
   a_illegal : assert property (@(posedge clk_i) disable iff (rst_i) illegal_o == exp_illegal)
      else report_mismatch("illegal_o", {31'h0, $sampled(illegal_o)},
                           {31'h0, $sampled(exp_illegal)});
   // flags in the order a, b, f, m
   a_flags : assert property (@(posedge clk_i) disable iff (rst_i) flags == exp_flags)
      else report_mismatch("is_abfm_supported_o", {28'h0, $sampled(flags)},
                           {28'h0, $sampled(exp_flags)});

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic access(input logic [1:0] op, input logic use_uimm,
                         input logic [11:0] addr, input logic [31:0] data);
      @(negedge clk_i);
      en_i                 = 1'b1;
      op_i                 = op;
      source_sel_i         = use_uimm;
      addr_i               = addr;
      // rs1 carries the inverse in uimm mode so that a wrong source select is seen
      rs1_value_i          = use_uimm ? ~data : data;
      rs1_label_i          = data[4:0];
      mret_i               = 1'b0;
      exception_detected_i = 1'b0;
      instr_retired_i      = 1'b0;
      accesses++;
   endtask

   task automatic read_csr(input logic [11:0] addr);
      access(csr_addr_pkg::OP_RS, 1'b1, addr, 32'h0);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         en_i                 = 1'b0;
         mret_i               = 1'b0;
         exception_detected_i = 1'b0;
         instr_retired_i      = 1'b0;
      end
   endtask

   task automatic wait_for_mepc(input logic [31:0] expected);
      int cycles;
      cycles = 0;
      while (mepc_o !== expected && cycles < 4) begin
         @(negedge clk_i);
         cycles++;
      end
      if (mepc_o !== expected) begin
         errors++;
         $display("mepc_o never took the trap pc %h within 4 cycles", expected);
      end
   endtask

   initial begin
      repeat (5000) @(posedge clk_i);
      $display("timeout: stimulus did not complete within 5000 cycles");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] b;
      int          n;
      seed     = 32'he6b6_d993;
      errors   = 0;
      accesses = 0;
      rst_i    = 1'b1;
      en_i     = 1'b0;
      op_i     = 2'b00;
      source_sel_i         = 1'b0;
      rs1_label_i          = 5'h0;
      rs1_value_i          = 32'h0;
      addr_i               = 12'h0;
      mret_i               = 1'b0;
      instr_retired_i      = 1'b0;
      exception_detected_i = 1'b0;
      exception_i          = 4'h0;
      pc_last_i            = 30'h0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      idle(2);

      // reset values of every mapped register
      read_csr(csr_addr_pkg::CSR_MSTATUS);
      read_csr(csr_addr_pkg::CSR_MISA);
      read_csr(csr_addr_pkg::CSR_MTVEC);
      read_csr(csr_addr_pkg::CSR_MSCRATCH);
      read_csr(csr_addr_pkg::CSR_MEPC);
      read_csr(csr_addr_pkg::CSR_MCAUSE);
      read_csr(csr_addr_pkg::CSR_MINSTRETH);
      idle(1);

      for (int i = 0; i < 40; i++) begin
         r = next_random();
         a = r[3] ? csr_addr_pkg::CSR_MTVEC : csr_addr_pkg::CSR_MSCRATCH;
         access(pick_op(r), r[2], a[11:0], next_random());
         read_csr(a[11:0]);
      end

      // misa keeps everything but A, B, F and M
      for (int i = 0; i < 12; i++) begin
         r = next_random();
         access(pick_op(r), r[2], csr_addr_pkg::CSR_MISA, next_random());
         read_csr(csr_addr_pkg::CSR_MISA);
      end

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // trap entry and mret
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      access(csr_addr_pkg::OP_RS, 1'b1, csr_addr_pkg::CSR_MSTATUS, 32'd8);
      read_csr(csr_addr_pkg::CSR_MSTATUS);
      for (int i = 0; i < 3; i++) begin
         r = next_random();
         access(csr_addr_pkg::OP_RW, 1'b0, csr_addr_pkg::CSR_MEPC, next_random());
         exception_detected_i = 1'b1;
         exception_i          = r[3:0];
         pc_last_i            = r[31:2];
         idle(1);
         wait_for_mepc({r[31:2], 2'b00});
         read_csr(csr_addr_pkg::CSR_MSTATUS);
         read_csr(csr_addr_pkg::CSR_MCAUSE);
         read_csr(csr_addr_pkg::CSR_MSTATUS);
         mret_i = 1'b1;
         read_csr(csr_addr_pkg::CSR_MSTATUS);
         read_csr(csr_addr_pkg::CSR_MEPC);
      end
      access(csr_addr_pkg::OP_RW, 1'b0, csr_addr_pkg::CSR_MCAUSE, next_random());
      read_csr(csr_addr_pkg::CSR_MCAUSE);

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // counters
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      read_csr(csr_addr_pkg::CSR_MCYCLE);
      @(negedge clk_i);
      a = read_o;
      n = 5 + int'(next_random() % 32'd16);
      repeat (n) @(negedge clk_i);
      b = read_o;
      assert (b - a == 32'(n)) else report_mismatch("mcycle delta", b - a, 32'(n));

      read_csr(csr_addr_pkg::CSR_MINSTRET);
      @(negedge clk_i);
      a = read_o;
      n = 3 + int'(next_random() % 32'd8);
      for (int i = 0; i < n; i++) begin
         instr_retired_i = 1'b1;
         @(negedge clk_i);
         instr_retired_i = 1'b0;
         if (next_random() > 32'h8000_0000)
            @(negedge clk_i);
      end
      b = read_o;
      assert (b - a == 32'(n)) else report_mismatch("minstret delta", b - a, 32'(n));

      access(csr_addr_pkg::OP_RW, 1'b0, csr_addr_pkg::CSR_MCYCLEH, next_random());
      read_csr(csr_addr_pkg::CSR_MCYCLEH);
      access(csr_addr_pkg::OP_RW, 1'b0, csr_addr_pkg::CSR_MCYCLE, next_random());
      read_csr(csr_addr_pkg::CSR_MCYCLE);
      access(csr_addr_pkg::OP_RW, 1'b0, csr_addr_pkg::CSR_MINSTRETH, next_random());
      read_csr(csr_addr_pkg::CSR_MINSTRETH);
      access(csr_addr_pkg::OP_RC, 1'b0, csr_addr_pkg::CSR_MINSTRET, next_random());
      instr_retired_i = 1'b1;
      read_csr(csr_addr_pkg::CSR_MINSTRET);

      // zero registers and unmapped addresses
      read_csr(csr_addr_pkg::CSR_MSTATUSH);
      read_csr(csr_addr_pkg::CSR_MTVAL);
      read_csr(12'h344);
      read_csr(12'h7C0);
      for (int i = 0; i < 6; i++) begin
         r = next_random();
         access(pick_op(r), r[2], r[27:16], next_random());
      end
      idle(4);

      $display("errors: %0d, csr accesses: %0d", errors, accesses);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
